/* rtl/burst_bus_pkg.sv */
`default_nettype none

package burst_bus_pkg;

    // Bus and storage sizes.
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 4;
    localparam int MEM_DEPTH = 16;
    localparam int LATENCY   = 4;
    localparam int MAX_BEATS = 8;
    localparam int CTRL_W    = 8;

    // Burst size field, buffer pointers and occupancy counts.
    localparam int SIZE_W = 2;
    localparam int PTR_W  = $clog2(MAX_BEATS);
    localparam int CNT_W  = PTR_W + 1;

    // Control field toward the slave, then the one coming back.
    localparam int CTRL_WE_BIT    = 1;
    localparam int CTRL_BURST_LSB = 2;
    localparam int CTRL_WAIT_BIT  = 0;

    // Host command word.
    localparam int CMD_W        = 8;
    localparam int CMD_OP_LSB   = 6;
    localparam int CMD_SIZE_LSB = 4;
    localparam int CMD_ADDR_LSB = 0;

    // Codes 0 and 3 are illegal.
    typedef enum logic [1:0] {
        OP_READ  = 2'd1,
        OP_WRITE = 2'd2
    } op_e;

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_ADDR,
        EX_WAIT,
        EX_DATA,
        EX_RELEASE
    } exec_state_e;

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_WRITE_WAIT,
        SL_READ_WAIT,
        SL_WRITE_DATA,
        SL_READ_DATA,
        SL_FINISH
    } slave_state_e;

endpackage

`default_nettype wire

/* rtl/cmd_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module cmd_decode import burst_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  logic [CMD_W-1:0]  cmd_word,
    input  logic              wr_valid,
    output logic              wr_ready,
    input  logic [DATA_W-1:0] wr_data,
    output logic              cmd_error,
    output logic              op_valid,
    input  logic              op_ready,
    output logic              op_write,
    output logic [ADDR_W-1:0] op_addr,
    output logic [SIZE_W-1:0] op_size,
    input  logic              buf_rd_en,
    output logic [DATA_W-1:0] buf_rd_data
);

    logic              accept_en;
    logic              collecting;
    logic [PTR_W-1:0]  beat_cnt;
    logic [PTR_W-1:0]  beat_last;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  buf_cnt;
    logic [DATA_W-1:0] buf_mem [MAX_BEATS];
    logic              cmd_fire;
    logic              wr_fire;
    op_e               cmd_op;

    assign cmd_op      = op_e'(cmd_word[CMD_OP_LSB +: 2]);
    // Commands are taken from the first cycle after reset.
    assign cmd_ready   = accept_en && !collecting && !op_valid;
    assign cmd_fire    = cmd_valid && cmd_ready;
    // A new write may collect while execute still drains the last one.
    assign wr_ready    = collecting && (buf_cnt != CNT_W'(MAX_BEATS));
    assign wr_fire     = wr_valid && wr_ready;
    assign beat_last   = PTR_W'((1 << op_size) - 1);
    assign buf_rd_data = buf_mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept_en  <= 1'b0;
            collecting <= 1'b0;
            op_valid   <= 1'b0;
            cmd_error  <= 1'b0;
            op_write   <= 1'b0;
            op_addr    <= '0;
            op_size    <= '0;
            beat_cnt   <= '0;
        end else begin
            accept_en <= 1'b1;
            cmd_error <= 1'b0;
            if (op_valid && op_ready) begin
                op_valid <= 1'b0;
            end
            if (cmd_fire) begin
                op_write <= (cmd_op == OP_WRITE);
                op_addr  <= cmd_word[CMD_ADDR_LSB +: ADDR_W];
                op_size  <= cmd_word[CMD_SIZE_LSB +: SIZE_W];
                beat_cnt <= '0;
                case (cmd_op)
                    OP_READ:  op_valid <= 1'b1;
                    OP_WRITE: collecting <= 1'b1;
                    default:  cmd_error <= 1'b1;
                endcase
            end
            if (wr_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (beat_cnt == beat_last) begin
                    collecting <= 1'b0;
                    op_valid   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            buf_cnt <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (buf_rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, buf_rd_en})
                2'b10:   buf_cnt <= buf_cnt + 1'b1;
                2'b01:   buf_cnt <= buf_cnt - 1'b1;
                default: buf_cnt <= buf_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            buf_mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/burst_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_execute import burst_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              op_valid,
    output logic              op_ready,
    input  logic              op_write,
    input  logic [ADDR_W-1:0] op_addr,
    input  logic [SIZE_W-1:0] op_size,
    output logic              buf_rd_en,
    input  logic [DATA_W-1:0] buf_rd_data,
    output logic              bus_ack,
    output logic [DATA_W-1:0] bus_to_slave,
    output logic [CTRL_W-1:0] ctrl_to_slave,
    input  logic [DATA_W-1:0] bus_from_slave,
    input  logic [CTRL_W-1:0] ctrl_from_slave,
    input  logic              res_empty,
    output logic              res_push,
    output logic [DATA_W-1:0] res_data,
    output logic              op_done
);

    exec_state_e       state;
    exec_state_e       next_state;
    logic              write_r;
    logic [ADDR_W-1:0] addr_r;
    logic [SIZE_W-1:0] size_r;
    logic [PTR_W-1:0]  beat_cnt;
    logic [PTR_W-1:0]  beat_last;
    logic              slave_wait;
    logic              op_fire;

    // A read needs the whole result FIFO free before it starts.
    assign op_ready   = (state == EX_IDLE) && (op_write || res_empty);
    assign op_fire    = op_valid && op_ready;
    assign slave_wait = ctrl_from_slave[CTRL_WAIT_BIT];
    assign beat_last  = PTR_W'((1 << size_r) - 1);

    assign bus_ack   = (state == EX_ADDR) || (state == EX_WAIT) || (state == EX_DATA);
    assign buf_rd_en = (state == EX_DATA) && write_r;
    assign res_push  = (state == EX_DATA) && !write_r;
    assign res_data  = bus_from_slave;

    always_comb begin
        bus_to_slave = '0;
        if (state == EX_ADDR) begin
            bus_to_slave[ADDR_W-1:0] = addr_r;
        end else if (buf_rd_en) begin
            bus_to_slave = buf_rd_data;
        end
    end

    // Write flag and burst size only matter in the address cycle.
    always_comb begin
        ctrl_to_slave = '0;
        if (state == EX_ADDR) begin
            ctrl_to_slave[CTRL_WE_BIT] = write_r;
            ctrl_to_slave[CTRL_BURST_LSB +: SIZE_W] = size_r;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            EX_IDLE: begin
                if (op_fire) begin
                    next_state = EX_ADDR;
                end
            end
            EX_ADDR: begin
                next_state = EX_WAIT;
            end
            EX_WAIT: begin
                // Wait drops in the slave's last latency cycle.
                if (!slave_wait) begin
                    next_state = EX_DATA;
                end
            end
            EX_DATA: begin
                if (beat_cnt == beat_last) begin
                    next_state = EX_RELEASE;
                end
            end
            EX_RELEASE: begin
                next_state = EX_IDLE;
            end
            default: begin
                next_state = EX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= EX_IDLE;
            write_r  <= 1'b0;
            addr_r   <= '0;
            size_r   <= '0;
            beat_cnt <= '0;
            op_done  <= 1'b0;
        end else begin
            state   <= next_state;
            op_done <= (state == EX_RELEASE);
            if (op_fire) begin
                write_r <= op_write;
                addr_r  <= op_addr;
                size_r  <= op_size;
            end
            if (state == EX_ADDR) begin
                beat_cnt <= '0;
            end else if (state == EX_DATA) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/read_result.sv */
`timescale 1ns/10ps
`default_nettype none

module read_result import burst_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              res_push,
    input  logic [DATA_W-1:0] res_data,
    output logic              res_empty,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_data
);

    logic [DATA_W-1:0] fifo_mem [MAX_BEATS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    assign res_empty = (count == '0);
    assign rsp_valid = !res_empty;
    assign rsp_data  = fifo_mem[rd_ptr];
    assign pop       = rsp_valid && rsp_ready;

    // Execute only pushes into an empty FIFO, so no full check.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (res_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({res_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (res_push) begin
            fifo_mem[wr_ptr] <= res_data;
        end
    end

endmodule

`default_nettype wire

/* rtl/burst_mem_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_mem_slave import burst_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              bus_ack,
    input  logic [DATA_W-1:0] bus_to_slave,
    input  logic [CTRL_W-1:0] ctrl_to_slave,
    output logic [DATA_W-1:0] bus_from_slave,
    output logic [CTRL_W-1:0] ctrl_from_slave
);

    localparam logic [CNT_W-1:0] LAT_LAST = CNT_W'(LATENCY - 1);

    slave_state_e      state;
    slave_state_e      next_state;
    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [CNT_W-1:0]  lat_cnt;
    logic [ADDR_W-1:0] word_addr;
    logic [PTR_W-1:0]  beat_cnt;
    logic [PTR_W-1:0]  beat_last;
    logic [SIZE_W-1:0] size_r;
    logic              we;
    logic              in_wait;
    logic              in_data;
    logic              wait_flag;

    assign we        = ctrl_to_slave[CTRL_WE_BIT];
    assign in_wait   = (state == SL_WRITE_WAIT) || (state == SL_READ_WAIT);
    assign in_data   = (state == SL_WRITE_DATA) || (state == SL_READ_DATA);
    assign beat_last = PTR_W'((1 << size_r) - 1);
    // Low in the last latency cycle so the master enters data on time.
    assign wait_flag = in_wait && (lat_cnt < LAT_LAST);

    assign bus_from_slave = (state == SL_READ_DATA) ? mem[word_addr] : '0;

    always_comb begin
        ctrl_from_slave = '0;
        ctrl_from_slave[CTRL_WAIT_BIT] = wait_flag;
    end

    always_comb begin
        next_state = state;
        case (state)
            SL_IDLE: begin
                if (bus_ack) begin
                    next_state = we ? SL_WRITE_WAIT : SL_READ_WAIT;
                end
            end
            SL_WRITE_WAIT: begin
                if (lat_cnt == LAT_LAST) begin
                    next_state = SL_WRITE_DATA;
                end
            end
            SL_READ_WAIT: begin
                if (lat_cnt == LAT_LAST) begin
                    next_state = SL_READ_DATA;
                end
            end
            SL_WRITE_DATA, SL_READ_DATA: begin
                if (beat_cnt == beat_last) begin
                    next_state = SL_FINISH;
                end
            end
            SL_FINISH: begin
                if (!bus_ack) begin
                    next_state = SL_IDLE;
                end
            end
            default: begin
                next_state = SL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SL_IDLE;
            lat_cnt   <= '0;
            word_addr <= '0;
            beat_cnt  <= '0;
            size_r    <= '0;
        end else begin
            state <= next_state;
            // Counter restarts at zero on every wait phase.
            if (in_wait) begin
                lat_cnt <= lat_cnt + 1'b1;
            end else begin
                lat_cnt <= '0;
            end
            if ((state == SL_IDLE) && bus_ack) begin
                word_addr <= bus_to_slave[ADDR_W-1:0];
                size_r    <= ctrl_to_slave[CTRL_BURST_LSB +: SIZE_W];
                beat_cnt  <= '0;
            end else if (in_data) begin
                word_addr <= word_addr + 1'b1;
                beat_cnt  <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == SL_WRITE_DATA) begin
            mem[word_addr] <= bus_to_slave;
        end
    end

endmodule

`default_nettype wire

/* rtl/burst_bus_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

module burst_bus_subsystem import burst_bus_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  logic [CMD_W-1:0]  cmd_word,
    input  logic              wr_valid,
    output logic              wr_ready,
    input  logic [DATA_W-1:0] wr_data,
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output logic [DATA_W-1:0] rsp_data,
    output logic              cmd_error,
    output logic              op_done
);

    logic              op_valid;
    logic              op_ready;
    logic              op_write;
    logic [ADDR_W-1:0] op_addr;
    logic [SIZE_W-1:0] op_size;
    logic              buf_rd_en;
    logic [DATA_W-1:0] buf_rd_data;
    logic              bus_ack;
    logic [DATA_W-1:0] bus_to_slave;
    logic [CTRL_W-1:0] ctrl_to_slave;
    logic [DATA_W-1:0] bus_from_slave;
    logic [CTRL_W-1:0] ctrl_from_slave;
    logic              res_push;
    logic [DATA_W-1:0] res_data;
    logic              res_empty;

    cmd_decode i_cmd_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_word    (cmd_word),
        .wr_valid    (wr_valid),
        .wr_ready    (wr_ready),
        .wr_data     (wr_data),
        .cmd_error   (cmd_error),
        .op_valid    (op_valid),
        .op_ready    (op_ready),
        .op_write    (op_write),
        .op_addr     (op_addr),
        .op_size     (op_size),
        .buf_rd_en   (buf_rd_en),
        .buf_rd_data (buf_rd_data)
    );

    burst_execute i_burst_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .op_valid        (op_valid),
        .op_ready        (op_ready),
        .op_write        (op_write),
        .op_addr         (op_addr),
        .op_size         (op_size),
        .buf_rd_en       (buf_rd_en),
        .buf_rd_data     (buf_rd_data),
        .bus_ack         (bus_ack),
        .bus_to_slave    (bus_to_slave),
        .ctrl_to_slave   (ctrl_to_slave),
        .bus_from_slave  (bus_from_slave),
        .ctrl_from_slave (ctrl_from_slave),
        .res_empty       (res_empty),
        .res_push        (res_push),
        .res_data        (res_data),
        .op_done         (op_done)
    );

    read_result i_read_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_push  (res_push),
        .res_data  (res_data),
        .res_empty (res_empty),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data)
    );

    burst_mem_slave i_burst_mem_slave (
        .clk             (clk),
        .rst_n           (rst_n),
        .bus_ack         (bus_ack),
        .bus_to_slave    (bus_to_slave),
        .ctrl_to_slave   (ctrl_to_slave),
        .bus_from_slave  (bus_from_slave),
        .ctrl_from_slave (ctrl_from_slave)
    );

endmodule

`default_nettype wire

/* bench/tb_burst_bus.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_burst_bus import burst_bus_pkg::*; ();

    localparam int WAIT_LIMIT = 200;
    localparam int EXP_DEPTH  = 1024;

    logic              clk = 1'b0;
    logic              rst_n = 1'b0;
    logic              cmd_valid = 1'b0;
    logic              cmd_ready;
    logic [CMD_W-1:0]  cmd_word = '0;
    logic              wr_valid = 1'b0;
    logic              wr_ready;
    logic [DATA_W-1:0] wr_data = '0;
    logic              rsp_valid;
    logic              rsp_ready = 1'b0;
    logic [DATA_W-1:0] rsp_data;
    logic              cmd_error;
    logic              op_done;

    // Reference memory and the words the host should see, in order.
    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    logic [DATA_W-1:0] exp_words [EXP_DEPTH];
    logic [9:0]        exp_wr = '0;
    logic [9:0]        exp_rd;
    logic [DATA_W-1:0] exp_head;
    logic              held_q;
    logic [DATA_W-1:0] held_data;
    logic              op_fire;
    logic              op_pending;
    logic              end_check = 1'b0;
    int                ready_mode = 2;
    int                cyc = 0;
    int                op_start;
    int                op_expect;
    int                legal_sent = 0;
    int                illegal_sent = 0;
    int                done_seen;
    int                error_seen;
    int                data_errs = 0;
    int                proto_errs = 0;
    int                timeout_errs = 0;

    always #2 clk = ~clk;

    burst_bus_subsystem i_burst_bus_subsystem (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd_word  (cmd_word),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_data   (wr_data),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_data  (rsp_data),
        .cmd_error (cmd_error),
        .op_done   (op_done)
    );

    assign op_fire  = i_burst_bus_subsystem.op_valid && i_burst_bus_subsystem.op_ready;
    assign exp_head = exp_words[exp_rd];

    // Mode 0 keeps the host ready, 1 toggles it randomly, 2 stalls it.
    always @(negedge clk) begin
        case (ready_mode)
            0:       rsp_ready = 1'b1;
            1:       rsp_ready = 1'($urandom);
            default: rsp_ready = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_rd     <= '0;
            held_q     <= 1'b0;
            held_data  <= '0;
            op_pending <= 1'b0;
            op_start   <= 0;
            op_expect  <= 0;
            done_seen  <= 0;
            error_seen <= 0;
        end else begin
            if (rsp_valid && rsp_ready) begin
                exp_rd <= exp_rd + 1'b1;
            end
            held_q    <= rsp_valid && !rsp_ready;
            held_data <= rsp_data;
            // Address cycle, wait phase, beats, release, then op_done.
            if (op_fire) begin
                op_pending <= 1'b1;
                op_start   <= cyc;
                op_expect  <= 1 + LATENCY + (1 << i_burst_bus_subsystem.op_size) + 2;
            end else if (op_done) begin
                op_pending <= 1'b0;
            end
            if (op_done) begin
                done_seen <= done_seen + 1;
            end
            if (cmd_error) begin
                error_seen <= error_seen + 1;
            end
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !cmd_ready && !wr_ready && !rsp_valid && !cmd_error && !op_done)
        else begin
            proto_errs = proto_errs + 1;
            $display("host output active during reset at %0t", $time);
        end

    rsp_order: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> rsp_data == exp_head)
        else begin
            data_errs = data_errs + 1;
            $display("mismatch at %0t: rsp_data expected %h got %h",
                     $time, $sampled(exp_head), $sampled(rsp_data));
        end

    rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> exp_rd != exp_wr)
        else begin
            proto_errs = proto_errs + 1;
            $display("read data offered with no read outstanding at %0t", $time);
        end

    rsp_held_valid: assert property (@(posedge clk) disable iff (!rst_n)
        held_q |-> rsp_valid)
        else begin
            proto_errs = proto_errs + 1;
            $display("rsp_valid dropped before the host took the word at %0t", $time);
        end

    rsp_held_data: assert property (@(posedge clk) disable iff (!rst_n)
        held_q |-> rsp_data == held_data)
        else begin
            data_errs = data_errs + 1;
            $display("mismatch at %0t: rsp_data expected %h got %h",
                     $time, $sampled(held_data), $sampled(rsp_data));
        end

    error_single: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_error |=> !cmd_error)
        else begin
            proto_errs = proto_errs + 1;
            $display("cmd_error held longer than one cycle at %0t", $time);
        end

    done_owner: assert property (@(posedge clk) disable iff (!rst_n)
        op_done |-> op_pending)
        else begin
            proto_errs = proto_errs + 1;
            $display("op_done with no accepted operation at %0t", $time);
        end

    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        op_done |-> (cyc - op_start) == op_expect)
        else begin
            proto_errs = proto_errs + 1;
            $display("mismatch at %0t: op_done latency expected %0d got %0d",
                     $time, $sampled(op_expect), $sampled(cyc) - $sampled(op_start));
        end

    one_op: assert property (@(posedge clk) disable iff (!rst_n)
        op_fire |-> !op_pending || op_done)
        else begin
            proto_errs = proto_errs + 1;
            $display("operation accepted while another was running at %0t", $time);
        end

    done_count: assert property (@(posedge clk) end_check |-> done_seen == legal_sent)
        else begin
            proto_errs = proto_errs + 1;
            $display("mismatch at %0t: op_done count expected %0d got %0d",
                     $time, $sampled(legal_sent), $sampled(done_seen));
        end

    error_count: assert property (@(posedge clk) end_check |-> error_seen == illegal_sent)
        else begin
            proto_errs = proto_errs + 1;
            $display("mismatch at %0t: cmd_error count expected %0d got %0d",
                     $time, $sampled(illegal_sent), $sampled(error_seen));
        end

    queue_empty: assert property (@(posedge clk) end_check |-> exp_rd == exp_wr)
        else begin
            proto_errs = proto_errs + 1;
            $display("expected read words left over at %0t", $time);
        end

    task automatic end_run();
        $display("errors: data %0d, protocol %0d, timeout %0d",
                 data_errs, proto_errs, timeout_errs);
        if (data_errs + proto_errs + timeout_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_errs = timeout_errs + 1;
        $display("timeout at %0t while waiting for %s", $time, what);
        end_run();
    endtask

    task automatic send_cmd(input logic [1:0] op, input logic [1:0] size,
                            input logic [3:0] addr);
        int n;
        n = 0;
        cmd_valid = 1'b1;
        cmd_word  = {op, size, addr};
        while (!cmd_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ready) begin
            report_timeout("cmd_ready");
        end
        if (op == OP_READ || op == OP_WRITE) begin
            legal_sent++;
        end else begin
            illegal_sent++;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_beat(input logic [DATA_W-1:0] word);
        int n;
        n = 0;
        wr_valid = 1'b1;
        wr_data  = word;
        while (!wr_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!wr_ready) begin
            report_timeout("wr_ready");
        end
        @(negedge clk);
        wr_valid = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!op_done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!op_done) begin
            report_timeout("op_done");
        end
        @(negedge clk);
    endtask

    task automatic wait_all_done();
        int n;
        n = 0;
        while (done_seen != legal_sent && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (done_seen != legal_sent) begin
            report_timeout("all operations to finish");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rd != exp_wr && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_rd != exp_wr) begin
            report_timeout("the read stream to drain");
        end
    endtask

    task automatic send_write(input logic [3:0] addr, input logic [1:0] size);
        logic [DATA_W-1:0] word;
        int i;
        send_cmd(OP_WRITE, size, addr);
        for (i = 0; i < (1 << size); i++) begin
            word = $urandom;
            ref_mem[addr + 4'(i)] = word;
            send_beat(word);
        end
    endtask

    task automatic do_write(input logic [3:0] addr, input logic [1:0] size);
        send_write(addr, size);
        wait_done();
    endtask

    task automatic queue_read(input logic [3:0] addr, input logic [1:0] size);
        int i;
        for (i = 0; i < (1 << size); i++) begin
            exp_words[exp_wr] = ref_mem[addr + 4'(i)];
            exp_wr = exp_wr + 1'b1;
        end
        send_cmd(OP_READ, size, addr);
    endtask

    task automatic send_illegal(input logic [1:0] op, input logic [3:0] addr);
        int n;
        send_cmd(op, 2'd3, addr);
        n = 0;
        while (!cmd_error && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_error) begin
            report_timeout("cmd_error");
        end
        repeat (12) @(negedge clk);
    endtask

    initial begin
        int k;
        logic [3:0] a;
        logic [1:0] s;
        void'($urandom(1605));
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // Fill all sixteen words first.
        do_write(4'd0, 2'd3);
        do_write(4'd8, 2'd3);
        ready_mode = 0;
        do_write(4'd5, 2'd2);
        queue_read(4'd5, 2'd2);
        wait_done();
        // Bursts that run past word 15.
        do_write(4'd14, 2'd3);
        queue_read(4'd13, 2'd3);
        wait_done();
        ready_mode = 1;
        for (k = 0; k < 24; k++) begin
            a = 4'($urandom_range(15, 0));
            s = 2'($urandom_range(3, 0));
            if ($urandom_range(1, 0) == 1) begin
                do_write(a, s);
            end else begin
                queue_read(a, s);
                wait_done();
            end
        end
        wait_drain();
        // A stalled host fills the FIFO and the next read has to wait.
        ready_mode = 2;
        queue_read(4'd2, 2'd3);
        wait_done();
        queue_read(4'd10, 2'd3);
        repeat (20) @(negedge clk);
        ready_mode = 1;
        wait_done();
        wait_drain();
        ready_mode = 0;
        // Commands queue in decode while the running burst finishes.
        send_write(4'd3, 2'd3);
        send_write(4'd9, 2'd2);
        queue_read(4'd3, 2'd3);
        wait_all_done();
        wait_drain();
        send_illegal(2'd0, 4'd6);
        send_illegal(2'd3, 4'd6);
        queue_read(4'd6, 2'd0);
        wait_done();
        wait_drain();
        end_check = 1'b1;
        @(negedge clk);
        end_check = 1'b0;
        @(negedge clk);
        end_run();
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/burst_bus_pkg.sv
rtl/cmd_decode.sv
rtl/burst_execute.sv
rtl/read_result.sv
rtl/burst_mem_slave.sv
rtl/burst_bus_subsystem.sv
bench/tb_burst_bus.sv

/* Makefile */
# Verilator build for the burst bus subsystem.
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_burst_bus
LOG       ?= sim.log
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

FAIL_TEXT := TEST RESULT: FAIL
PASS_TEXT := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
